// ==== pdp8.f ====
+incdir+.
pdp8_pkg.sv
pdp8_memory.sv
pdp8_mri_unit.sv
pdp8_operate.sv
pdp8_sequencer.sv
pdp8_top.sv
pdp8_tb.sv

// ==== pdp8_tb_tasks.svh ====
// PDP-8 testbench helpers for host port driving, compare tasks and reference models
`ifndef PDP8_TB_TASKS_SVH
`define PDP8_TB_TASKS_SVH

task automatic fail_run();
	$display("TEST RESULT: FAIL");
	$fatal(1);
endtask

task automatic check_word(input string name, input word_t expected, input word_t actual);
	if (actual !== expected) begin
		$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		fail_run();
	end
endtask

task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
	if (actual !== expected) begin
		$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		fail_run();
	end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		fail_run();
	end
endtask

task automatic check_regs(input string name, input arch_regs_t expected, input arch_regs_t actual);
	if (actual !== expected) begin
		$display("CHECK FAILED %s expected ac %h link %h mq %h actual ac %h link %h mq %h",
			name, expected.ac, expected.link, expected.mq, actual.ac, actual.link, actual.mq);
		fail_run();
	end
endtask

function automatic word_t rand_word();
	return word_t'($urandom);
endfunction

function automatic logic rand_bit();
	word_t r;
	r = rand_word();
	return r[0];
endfunction

// Memory-reference word: opcode, indirect bit, page bit, offset
function automatic word_t mri_word(input opcode_e op, input logic ind, input logic cur,
		input logic [OFFSET_W-1:0] off);
	return {op, ind, cur, off};
endfunction

task automatic load_word(input addr_t addr, input word_t data);
	host = '{load: 1'b1, start: 1'b0, addr: addr, data: data};  // One-cycle load strobe
	@(posedge clk);
	#1;
	host = '0;
endtask

task automatic check_mem(input addr_t addr, input word_t expected);
	peek_addr = addr;
	@(posedge clk);  // Registered read, word valid after this edge
	#1;
	check_word($sformatf("mem[%o]", addr), expected, peek_data);
endtask

// Start strobe, then wait for the halt flag
task automatic run_program(input addr_t start_pc, input word_t sw);
	switches = sw;
	host = '{load: 1'b0, start: 1'b1, addr: start_pc, data: '0};
	@(posedge clk);
	#1;
	host = '0;
	check_bit("o_running", 1'b1, running);
	check_bit("o_halted", 1'b0, halted);  // Start clears the old halt
	while (!halted) begin
		@(posedge clk);
		#1;
	end
	check_bit("o_running", 1'b0, running);  // Drops with the halt
endtask

// TAD, a carry out of the sign position complements the link
function automatic arch_regs_t tad_model(input arch_regs_t r, input word_t operand);
	int unsigned total;
	total = r.ac + operand;
	r.ac = total[WORD_W-1:0];
	if (total >= (1 << WORD_W)) r.link = ~r.link;
	return r;
endfunction

// Group 1 in machine order: clears, complements, increment, rotates
function automatic arch_regs_t group1_model(input arch_regs_t r, input word_t instr);
	logic carry;
	int   turns;
	if (instr[7]) r.ac = '0;        // CLA
	if (instr[6]) r.link = 1'b0;    // CLL
	if (instr[5]) r.ac = ~r.ac;     // CMA
	if (instr[4]) r.link = ~r.link; // CML
	if (instr[0]) begin             // IAC
		if (r.ac == 12'o7777) r.link = ~r.link;
		r.ac = r.ac + 1'b1;
	end
	turns = instr[1] ? 2 : 1;       // Two places for RTR and RTL
	repeat (turns) begin
		if (instr[3]) begin         // Right through the link
			carry = r.ac[0];
			r.ac = {r.link, r.ac[WORD_W-1:1]};
			r.link = carry;
		end else if (instr[2]) begin  // Left through the link
			carry = r.ac[WORD_W-1];
			r.ac = {r.ac[WORD_W-2:0], r.link};
			r.link = carry;
		end
	end
	return r;
endfunction

// Group 2 skip decision on the AC and link before the instruction
function automatic logic skip_model(input word_t instr, input arch_regs_t r);
	logic neg;
	logic zero;
	logic result;
	neg = r.ac[WORD_W-1];
	zero = (r.ac == '0);
	if (!instr[3]) begin  // OR subgroup, any chosen condition
		result = (instr[6] && neg) || (instr[5] && zero) || (instr[4] && r.link);
	end else begin        // AND subgroup, all chosen hold, none chosen is SKP
		result = (!instr[6] || !neg) && (!instr[5] || !zero) && (!instr[4] || !r.link);
	end
	return result;
endfunction

// Group 3, CLA first then the MQ moves
function automatic arch_regs_t group3_model(input arch_regs_t r, input word_t instr);
	word_t ac;
	ac = instr[7] ? '0 : r.ac;
	if (instr[6] && instr[4]) begin  // SWP
		r.ac = r.mq;
		r.mq = ac;
	end else if (instr[6]) begin     // MQA
		r.ac = ac | r.mq;
	end else if (instr[4]) begin     // MQL
		r.mq = ac;
		r.ac = '0;
	end else begin
		r.ac = ac;
	end
	return r;
endfunction

`endif

// ==== pdp8_tb.sv ====
// PDP-8 core testbench, directed programs for memory-reference and operate instructions
`timescale 1ns/1ps

module pdp8_tb
	import pdp8_pkg::*;
();

	localparam int    RESET_CYCLES = 16;
	localparam addr_t ORIGIN  = 12'o0200;  // Programs start on page 1
	localparam word_t CLA_CLL = 12'o7300;
	localparam word_t NOP     = 12'o7000;
	localparam word_t CML     = 12'o7020;
	localparam word_t HLT     = 12'o7402;
	localparam arch_regs_t CLEAR_REGS = '0;
	// Totals over all tests, skip programs counted at their longest path
	localparam int LOADED_WORDS    = 10 + 7 + 7 + 9 + 4*6 + 28*8 + 5 + 10 + 6;
	localparam int EXECUTED_INSTRS = 6 + 25 + 5 + 5 + 4*5 + 28*6 + 4 + 8 + 6;
	localparam int WATCHDOG_CYCLES = 64 * LOADED_WORDS + 200 * EXECUTED_INSTRS;

	logic       clk = 1'b0;
	logic       reset;
	host_cmd_t  host;
	addr_t      peek_addr;
	word_t      switches;
	word_t      peek_data;
	logic       running;
	logic       halted;
	addr_t      pc;
	arch_regs_t regs;
	int unsigned seed_used;

	pdp8_top i_dut (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_host      (host),
		.i_peek_addr (peek_addr),
		.i_switches  (switches),
		.o_peek_data (peek_data),
		.o_running   (running),
		.o_halted    (halted),
		.o_pc        (pc),
		.o_regs      (regs)
	);

	`include "pdp8_tb_tasks.svh"

	always #2 clk = ~clk;  // 4 ns period

	// Reset state, then TAD AND TAD DCA on random operands
	task automatic test_basic_mri();
		word_t      a;
		word_t      b;
		word_t      c;
		word_t      stored;
		arch_regs_t exp;
		a = rand_word();
		b = rand_word();
		c = rand_word();
		check_bit("o_running", 1'b0, running);
		check_bit("o_halted", 1'b0, halted);
		check_regs("o_regs", CLEAR_REGS, regs);
		load_word(12'o0200, CLA_CLL);
		load_word(12'o0201, mri_word(OP_TAD, 1'b0, 1'b1, 7'o50));
		load_word(12'o0202, mri_word(OP_AND, 1'b0, 1'b1, 7'o51));
		load_word(12'o0203, mri_word(OP_TAD, 1'b0, 1'b1, 7'o52));
		load_word(12'o0204, mri_word(OP_DCA, 1'b0, 1'b1, 7'o53));
		load_word(12'o0205, HLT);
		load_word(12'o0250, a);
		load_word(12'o0251, b);
		load_word(12'o0252, c);
		load_word(12'o0253, rand_word());  // Overwritten by DCA
		run_program(ORIGIN, '0);
		exp = tad_model(CLEAR_REGS, a);
		exp.ac = exp.ac & b;
		exp = tad_model(exp, c);
		stored = exp.ac;
		exp.ac = '0;
		check_regs("o_regs", exp, regs);
		check_addr("o_pc", 12'o0206, pc);
		check_mem(12'o0253, stored);
	endtask

	// Counter at minus N, ISZ skips the JMP back once it wraps
	task automatic test_isz_loop();
		int         n;
		word_t      addend;
		arch_regs_t exp;
		n = 1 + ($urandom % 8);
		addend = rand_word();
		load_word(12'o0200, CLA_CLL);
		load_word(12'o0201, mri_word(OP_TAD, 1'b0, 1'b1, 7'o50));
		load_word(12'o0202, mri_word(OP_ISZ, 1'b0, 1'b1, 7'o51));
		load_word(12'o0203, mri_word(OP_JMP, 1'b0, 1'b1, 7'o01));
		load_word(12'o0204, HLT);
		load_word(12'o0250, addend);
		load_word(12'o0251, word_t'(0 - n));
		run_program(ORIGIN, '0);
		exp = CLEAR_REGS;
		repeat (n) exp = tad_model(exp, addend);
		check_regs("o_regs", exp, regs);
		check_addr("o_pc", 12'o0205, pc);
		check_mem(12'o0251, '0);
	endtask

	// JMS with indirect return, then three reads through auto-index 010
	task automatic test_jms_autoindex();
		word_t      value;
		word_t      data [3];
		arch_regs_t exp;
		int         i;
		value = rand_word();
		load_word(12'o0200, CLA_CLL);
		load_word(12'o0201, mri_word(OP_JMS, 1'b0, 1'b1, 7'o20));
		load_word(12'o0202, HLT);
		load_word(12'o0220, rand_word());  // Entry word, gets the return address
		load_word(12'o0221, mri_word(OP_TAD, 1'b0, 1'b1, 7'o50));
		load_word(12'o0222, mri_word(OP_JMP, 1'b1, 1'b1, 7'o20));
		load_word(12'o0250, value);
		run_program(ORIGIN, '0);
		check_regs("o_regs", tad_model(CLEAR_REGS, value), regs);
		check_addr("o_pc", 12'o0203, pc);
		check_mem(12'o0220, 12'o0202);

		load_word(12'o0010, 12'o0277);  // Pointer, first use is 0300
		load_word(12'o0200, CLA_CLL);
		for (i = 0; i < 3; i++) begin
			data[i] = rand_word();
			load_word(addr_t'(12'o0201 + i), mri_word(OP_TAD, 1'b1, 1'b0, 7'o10));
			load_word(addr_t'(12'o0300 + i), data[i]);
		end
		load_word(12'o0204, HLT);
		run_program(ORIGIN, '0);
		exp = CLEAR_REGS;
		for (i = 0; i < 3; i++) exp = tad_model(exp, data[i]);
		check_regs("o_regs", exp, regs);
		check_addr("o_pc", 12'o0205, pc);
		check_mem(12'o0010, 12'o0302);
	endtask

	// One op per program on a random AC and link
	task automatic test_group1();
		word_t      ops [4];
		word_t      value;
		logic       link_in;
		arch_regs_t exp;
		int         i;
		ops[0] = 12'o7341;  // CLA CLL CMA IAC
		ops[1] = 12'o7024;  // CML RAL
		ops[2] = 12'o7012;  // RTR
		ops[3] = 12'o7006;  // RTL
		for (i = 0; i < 4; i++) begin
			value = rand_word();
			link_in = rand_bit();
			load_word(12'o0200, CLA_CLL);
			load_word(12'o0201, mri_word(OP_TAD, 1'b0, 1'b1, 7'o50));
			load_word(12'o0202, link_in ? CML : NOP);
			load_word(12'o0203, ops[i]);
			load_word(12'o0204, HLT);
			load_word(12'o0250, value);
			run_program(ORIGIN, '0);
			exp = tad_model(CLEAR_REGS, value);
			exp.link = link_in;
			check_regs("o_regs", group1_model(exp, ops[i]), regs);
			check_addr("o_pc", 12'o0205, pc);
		end
	endtask

	// Skip shown by an ISZ marker after the skip, then CLA OSR and HLT
	task automatic test_group2();
		word_t      skips [7];
		word_t      value;
		word_t      sw;
		logic       link_in;
		arch_regs_t exp;
		int         i;
		int         j;
		skips[0] = 12'o7500;  // SMA
		skips[1] = 12'o7440;  // SZA
		skips[2] = 12'o7420;  // SNL
		skips[3] = 12'o7510;  // SPA
		skips[4] = 12'o7450;  // SNA
		skips[5] = 12'o7430;  // SZL
		skips[6] = 12'o7410;  // SKP
		for (i = 0; i < 7; i++) begin
			for (j = 0; j < 4; j++) begin
				value = rand_word();
				link_in = rand_bit();
				case (j)
					0: begin
						value = '0;
						link_in = 1'b0;
					end
					1: begin
						value = value | 12'o4000;  // Negative
						link_in = 1'b1;
					end
					2: begin
						value = (value & 12'o3777) | 12'o0001;  // Positive, nonzero
						link_in = 1'b0;
					end
					default: value = value;
				endcase
				load_word(12'o0200, CLA_CLL);
				load_word(12'o0201, mri_word(OP_TAD, 1'b0, 1'b1, 7'o50));
				load_word(12'o0202, link_in ? CML : NOP);
				load_word(12'o0203, skips[i]);
				load_word(12'o0204, mri_word(OP_ISZ, 1'b0, 1'b1, 7'o51));  // Marker
				load_word(12'o0205, HLT);
				load_word(12'o0250, value);
				load_word(12'o0251, '0);
				run_program(ORIGIN, '0);
				exp = tad_model(CLEAR_REGS, value);
				exp.link = link_in;
				check_regs("o_regs", exp, regs);
				check_addr("o_pc", 12'o0206, pc);
				check_mem(12'o0251, skip_model(skips[i], exp) ? 12'o0000 : 12'o0001);
			end
		end
		sw = rand_word();
		load_word(12'o0200, CLA_CLL);
		load_word(12'o0201, mri_word(OP_TAD, 1'b0, 1'b1, 7'o50));
		load_word(12'o0202, 12'o7604);  // CLA OSR
		load_word(12'o0203, HLT);
		load_word(12'o0250, rand_word());
		run_program(ORIGIN, sw);
		exp = CLEAR_REGS;
		exp.ac = sw;
		check_regs("o_regs", exp, regs);
		check_addr("o_pc", 12'o0204, pc);
		repeat (4) @(posedge clk);  // Stopped core holds its state
		#1;
		check_bit("o_halted", 1'b1, halted);
		check_addr("o_pc", 12'o0204, pc);
	endtask

	// MQL, MQA, IOT, SWP, then a CAM program
	task automatic test_group3();
		word_t      a;
		word_t      b;
		arch_regs_t exp;
		a = rand_word();
		b = rand_word();
		load_word(12'o0200, CLA_CLL);
		load_word(12'o0201, mri_word(OP_TAD, 1'b0, 1'b1, 7'o50));
		load_word(12'o0202, 12'o7421);  // MQL
		load_word(12'o0203, mri_word(OP_TAD, 1'b0, 1'b1, 7'o51));
		load_word(12'o0204, 12'o7501);  // MQA
		load_word(12'o0205, 12'o6046);  // IOT, only the PC moves
		load_word(12'o0206, 12'o7521);  // SWP
		load_word(12'o0207, HLT);
		load_word(12'o0250, a);
		load_word(12'o0251, b);
		run_program(ORIGIN, '0);
		exp = tad_model(CLEAR_REGS, a);  // MQ still clear from reset
		exp = group3_model(exp, 12'o7421);
		exp = tad_model(exp, b);
		exp = group3_model(exp, 12'o7501);
		exp = group3_model(exp, 12'o7521);
		check_regs("o_regs", exp, regs);
		check_addr("o_pc", 12'o0210, pc);

		a = rand_word();
		b = rand_word();
		load_word(12'o0200, CLA_CLL);
		load_word(12'o0202, 12'o7421);  // MQL
		load_word(12'o0204, 12'o7621);  // CAM
		load_word(12'o0205, HLT);
		load_word(12'o0250, a);
		load_word(12'o0251, b);
		run_program(ORIGIN, '0);
		exp.ac = '0;
		exp.link = 1'b0;
		exp = tad_model(exp, a);
		exp = group3_model(exp, 12'o7421);
		exp = tad_model(exp, b);
		exp = group3_model(exp, 12'o7621);
		check_regs("o_regs", exp, regs);
		check_addr("o_pc", 12'o0206, pc);
	endtask

	initial begin
		seed_used = $urandom(32'h6fde_c7ad);
		reset = 1'b1;
		host = '0;
		peek_addr = '0;
		switches = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		test_basic_mri();
		test_isz_loop();
		test_jms_autoindex();
		test_group1();
		test_group2();
		test_group3();
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		fail_run();
	end

endmodule

// ==== pdp8_top.sv ====
// PDP-8 core top, joins memory, both execution units and the sequencer, muxes the host port
`timescale 1ns/1ps

module pdp8_top
	import pdp8_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  host_cmd_t  i_host,       // Load and start strobes
	input  addr_t      i_peek_addr,  // Host read address while stopped
	input  word_t      i_switches,   // Switch register for OSR
	output word_t      o_peek_data,  // Peeked word, one cycle later
	output logic       o_running,
	output logic       o_halted,
	output addr_t      o_pc,
	output arch_regs_t o_regs
);

	mem_req_t    seq_mem;    // Sequencer request
	mem_req_t    mem_req;    // Request at the RAM
	word_t       mem_rdata;
	word_t       instr;
	word_t       operand;
	opcode_e     opcode;
	arch_regs_t  regs;
	mri_result_t mri;
	opr_result_t opr;
	logic        running;

	// Host owns the port whenever the core is stopped
	always_comb begin
		if (running) begin
			mem_req = seq_mem;
		end else begin
			mem_req.addr  = i_host.load ? i_host.addr : i_peek_addr;  // Load wins over peek
			mem_req.wdata = i_host.data;
			mem_req.we    = i_host.load;
		end
	end

	pdp8_memory u_memory (
		.i_clk   (i_clk),
		.i_addr  (mem_req.addr),
		.i_wdata (mem_req.wdata),
		.i_we    (mem_req.we),
		.o_rdata (mem_rdata)
	);

	pdp8_mri_unit u_mri (
		.i_opcode  (opcode),
		.i_regs    (regs),
		.i_operand (operand),
		.i_pc      (o_pc),
		.o_result  (mri)
	);

	pdp8_operate u_operate (
		.i_instr    (instr),
		.i_regs     (regs),
		.i_switches (i_switches),
		.o_result   (opr)
	);

	pdp8_sequencer u_sequencer (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_start     (i_host.start),  // Ignored unless idle
		.i_start_pc  (i_host.addr),
		.i_mem_rdata (mem_rdata),
		.i_mri       (mri),
		.i_opr       (opr),
		.o_mem       (seq_mem),
		.o_instr     (instr),
		.o_opcode    (opcode),
		.o_operand   (operand),
		.o_regs      (regs),
		.o_pc        (o_pc),
		.o_running   (running),
		.o_halted    (o_halted)
	);

	assign o_peek_data = mem_rdata;
	assign o_running   = running;
	assign o_regs      = regs;

endmodule

// ==== pdp8_sequencer.sv ====
// PDP-8 sequencer, fetch/address/execute FSM holding PC, IR, MB, effective address, AC, link, MQ
`timescale 1ns/1ps

module pdp8_sequencer
	import pdp8_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_start,      // Run strobe from the host
	input  addr_t       i_start_pc,   // First PC on start
	input  word_t       i_mem_rdata,  // Memory word, one cycle after its address
	input  mri_result_t i_mri,        // Memory-reference results
	input  opr_result_t i_opr,        // Operate results
	output mem_req_t    o_mem,        // Memory port request while running
	output word_t       o_instr,      // IR
	output opcode_e     o_opcode,     // IR opcode field
	output word_t       o_operand,    // MB
	output arch_regs_t  o_regs,
	output addr_t       o_pc,
	output logic        o_running,
	output logic        o_halted
);

	typedef enum logic [3:0] {
		S_IDLE,        // Waiting for start
		S_FETCH_ADDR,  // Instruction address out
		S_FETCH_DATA,  // Instruction word back, decode
		S_PTR_ADDR,    // Indirect pointer address out
		S_PTR_DATA,    // Pointer word back
		S_AUTO_WRITE,  // Incremented auto-index pointer stored
		S_OPND_ADDR,   // Operand address out
		S_OPND_DATA,   // Operand word back
		S_WRITE,       // Store for ISZ, DCA, JMS
		S_EXEC         // Commit registers and PC
	} state_e;

	state_e  state;
	addr_t   pc;
	addr_t   ea;        // Effective address, pointer address during indirection
	word_t   ir;
	word_t   mb;        // Memory buffer, operand or incremented pointer
	word_t   ac;
	word_t   mq;
	logic    link;
	logic    running;
	logic    halted;
	opcode_e opcode;      // Opcode of the held instruction
	opcode_e fetch_op;    // Opcode of the word being fetched
	addr_t   fetch_ea;    // Direct address of the word being fetched
	logic    is_auto;     // Pointer sits in the auto-index window
	logic    skip;        // Selected skip at execute

	// Where to go once the effective address is final
	function automatic state_e addr_done(opcode_e op);
		case (op)
			OP_AND, OP_TAD, OP_ISZ: return S_OPND_ADDR;  // Need the operand
			OP_DCA, OP_JMS:         return S_WRITE;      // Store only
			default:                return S_EXEC;       // JMP
		endcase
	endfunction

	assign opcode   = opcode_e'(ir[WORD_W-1 -: 3]);
	assign fetch_op = opcode_e'(i_mem_rdata[WORD_W-1 -: 3]);
	// Page bit picks current page or page zero
	assign fetch_ea = i_mem_rdata[OFFSET_W] ?
		{pc[ADDR_W-1 -: PAGE_W], i_mem_rdata[OFFSET_W-1:0]} :
		{{PAGE_W{1'b0}}, i_mem_rdata[OFFSET_W-1:0]};
	assign is_auto  = (ea >= AUTOINDEX_FIRST) && (ea <= AUTOINDEX_LAST);
	assign skip     = (opcode == OP_OPR) ? i_opr.skip : i_mri.skip;

	// Memory port request by state
	always_comb begin
		o_mem.addr  = pc;  // Fetch address by default
		o_mem.wdata = i_mri.mem_data;
		o_mem.we    = 1'b0;
		case (state)
			S_PTR_ADDR, S_OPND_ADDR: o_mem.addr = ea;
			S_AUTO_WRITE: begin
				o_mem.addr  = ea;  // Pointer location
				o_mem.wdata = mb;  // Incremented pointer
				o_mem.we    = 1'b1;
			end
			S_WRITE: begin
				o_mem.addr = ea;
				o_mem.we   = 1'b1;
			end
			default: o_mem.we = 1'b0;
		endcase
	end

	// Control state and architectural registers
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state   <= S_IDLE;
			pc      <= '0;
			ac      <= '0;
			link    <= 1'b0;
			mq      <= '0;
			running <= 1'b0;
			halted  <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (i_start) begin
						pc      <= i_start_pc;
						running <= 1'b1;
						halted  <= 1'b0;  // Cleared by the next start
						state   <= S_FETCH_ADDR;
					end
				end
				S_FETCH_ADDR: state <= S_FETCH_DATA;
				S_FETCH_DATA: begin
					if (fetch_op == OP_IOT || fetch_op == OP_OPR) begin
						state <= S_EXEC;  // No address phase
					end else if (i_mem_rdata[OFFSET_W+1]) begin
						state <= S_PTR_ADDR;  // Indirect bit
					end else begin
						state <= addr_done(fetch_op);
					end
				end
				S_PTR_ADDR:   state <= S_PTR_DATA;
				S_PTR_DATA:   state <= is_auto ? S_AUTO_WRITE : addr_done(opcode);
				S_AUTO_WRITE: state <= addr_done(opcode);
				S_OPND_ADDR:  state <= S_OPND_DATA;
				S_OPND_DATA:  state <= i_mri.mem_write ? S_WRITE : S_EXEC;  // ISZ stores
				S_WRITE:      state <= S_EXEC;
				S_EXEC: begin
					if (opcode == OP_OPR) begin
						ac   <= i_opr.ac;
						link <= i_opr.link;
						mq   <= i_opr.mq;
					end else if (opcode != OP_IOT) begin
						ac   <= i_mri.ac;
						link <= i_mri.link;
					end
					case (opcode)
						OP_JMS:  pc <= ea + 1'b1;  // First word after the entry
						OP_JMP:  pc <= ea;
						default: pc <= pc + (skip ? 12'd2 : 12'd1);
					endcase
					if (opcode == OP_OPR && i_opr.halt) begin
						running <= 1'b0;
						halted  <= 1'b1;
						state   <= S_IDLE;
					end else begin
						state <= S_FETCH_ADDR;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Instruction, buffer and address registers
	always_ff @(posedge i_clk) begin
		case (state)
			S_FETCH_DATA: begin
				ir <= i_mem_rdata;
				ea <= fetch_ea;
			end
			S_PTR_DATA: begin
				if (is_auto) begin
					mb <= i_mem_rdata + 1'b1;  // Pre-increment pointer
				end else begin
					ea <= i_mem_rdata;  // Follow the pointer
				end
			end
			S_AUTO_WRITE: ea <= mb;  // Use the incremented pointer
			S_OPND_DATA:  mb <= i_mem_rdata;
			default: mb <= mb;
		endcase
	end

	assign o_instr   = ir;
	assign o_opcode  = opcode;
	assign o_operand = mb;
	assign o_regs    = '{ac: ac, link: link, mq: mq};
	assign o_pc      = pc;
	assign o_running = running;
	assign o_halted  = halted;

endmodule

// ==== pdp8_operate.sv ====
// PDP-8 operate unit, decodes and executes Group 1, 2 and 3 microinstructions
`timescale 1ns/1ps

module pdp8_operate
	import pdp8_pkg::*;
(
	input  word_t       i_instr,     // Full instruction word
	input  arch_regs_t  i_regs,      // AC, link and MQ before the instruction
	input  word_t       i_switches,  // Front-panel switch register
	output opr_result_t o_result
);

	// Instruction bits, named after the machine's bit numbers
	logic grp_sel;  // Bit 3, clear for Group 1
	logic bit_cla;  // Bit 4, CLA in every group
	logic bit_5;    // CLL, SMA/SPA or MQA
	logic bit_6;    // CMA or SZA/SNA
	logic bit_7;    // CML, SNL/SZL or MQL
	logic bit_8;    // RAR or AND-subgroup select
	logic bit_9;    // RAL or OSR
	logic bit_10;   // Rotate twice or HLT
	logic bit_11;   // IAC, or Group 3 select

	logic [WORD_W:0] lac;  // Link and AC as one 13-bit value, link on top
	word_t           ac;   // Working AC for Groups 2 and 3
	logic            or_cond;  // Any OR-subgroup condition true

	assign grp_sel = i_instr[8];
	assign bit_cla = i_instr[7];
	assign bit_5   = i_instr[6];
	assign bit_6   = i_instr[5];
	assign bit_7   = i_instr[4];
	assign bit_8   = i_instr[3];
	assign bit_9   = i_instr[2];
	assign bit_10  = i_instr[1];
	assign bit_11  = i_instr[0];

	always_comb begin
		o_result.ac   = i_regs.ac;
		o_result.link = i_regs.link;
		o_result.mq   = i_regs.mq;
		o_result.skip = 1'b0;
		o_result.halt = 1'b0;
		lac     = {i_regs.link, i_regs.ac};
		ac      = i_regs.ac;
		or_cond = 1'b0;

		if (!grp_sel) begin  // Group 1, steps in machine order
			if (bit_cla) lac[WORD_W-1:0] = '0;       // CLA
			if (bit_5)   lac[WORD_W]     = 1'b0;     // CLL
			if (bit_6)   lac[WORD_W-1:0] = ~lac[WORD_W-1:0];  // CMA
			if (bit_7)   lac[WORD_W]     = ~lac[WORD_W];      // CML
			if (bit_11)  lac             = lac + 1'b1;  // IAC, carry lands in link
			if (bit_8) begin  // RAR, RTR when bit 10 set
				lac = {lac[0], lac[WORD_W:1]};
				if (bit_10) lac = {lac[0], lac[WORD_W:1]};
			end else if (bit_9) begin  // RAL, RTL when bit 10 set
				lac = {lac[WORD_W-1:0], lac[WORD_W]};
				if (bit_10) lac = {lac[WORD_W-1:0], lac[WORD_W]};
			end
			o_result.ac   = lac[WORD_W-1:0];
			o_result.link = lac[WORD_W];
		end else if (!bit_11) begin  // Group 2
			// Conditions read the AC before CLA
			or_cond = (bit_5 & i_regs.ac[WORD_W-1])  // SMA
				| (bit_6 & (i_regs.ac == '0))        // SZA
				| (bit_7 & i_regs.link);              // SNL
			o_result.skip = or_cond ^ bit_8;  // AND subgroup is the inverse, SKP alone
			if (bit_cla) ac = '0;              // CLA
			if (bit_9)   ac = ac | i_switches; // OSR
			o_result.ac   = ac;
			o_result.halt = bit_10;            // HLT
		end else begin  // Group 3
			if (bit_cla) ac = '0;  // CLA first
			case ({bit_5, bit_7})
				2'b11: begin  // SWP
					o_result.ac = i_regs.mq;
					o_result.mq = ac;
				end
				2'b10: begin  // MQA
					o_result.ac = ac | i_regs.mq;
				end
				2'b01: begin  // MQL, CAM with CLA
					o_result.mq = ac;
					o_result.ac = '0;
				end
				default: begin
					o_result.ac = ac;  // CLA alone or no-op
				end
			endcase
		end
	end

endmodule

// ==== pdp8_mri_unit.sv ====
// PDP-8 memory-reference data unit, computes AC, link and store word for AND TAD ISZ DCA JMS
`timescale 1ns/1ps

module pdp8_mri_unit
	import pdp8_pkg::*;
(
	input  opcode_e     i_opcode,   // Current major opcode
	input  arch_regs_t  i_regs,     // AC, link and MQ before the instruction
	input  word_t       i_operand,  // Memory operand from MB
	input  addr_t       i_pc,       // Address of this instruction
	output mri_result_t o_result
);

	logic [WORD_W:0] sum;  // 13-bit TAD sum, top bit is the carry

	assign sum = {1'b0, i_regs.ac} + {1'b0, i_operand};

	always_comb begin
		o_result.ac        = i_regs.ac;    // Unchanged unless the opcode says so
		o_result.link      = i_regs.link;
		o_result.mem_data  = i_operand;
		o_result.mem_write = 1'b0;
		o_result.skip      = 1'b0;
		case (i_opcode)
			OP_AND: begin
				o_result.ac = i_regs.ac & i_operand;  // Mask AC
			end
			OP_TAD: begin
				o_result.ac   = sum[WORD_W-1:0];
				o_result.link = i_regs.link ^ sum[WORD_W];  // Carry out flips link
			end
			OP_ISZ: begin
				o_result.mem_data  = i_operand + 1'b1;  // Incremented word goes back
				o_result.mem_write = 1'b1;
				o_result.skip      = (i_operand == '1);  // Wraps to zero
			end
			OP_DCA: begin
				o_result.mem_data  = i_regs.ac;  // Deposit AC
				o_result.mem_write = 1'b1;
				o_result.ac        = '0;          // Then clear it
			end
			OP_JMS: begin
				o_result.mem_data  = i_pc + 1'b1;  // Return address into the entry word
				o_result.mem_write = 1'b1;
			end
			default: begin
				// JMP, IOT and OPR leave the data path alone
				o_result.mem_write = 1'b0;
			end
		endcase
	end

endmodule

// ==== pdp8_memory.sv ====
// PDP-8 core memory, 4K words of single-port synchronous RAM with registered read
`timescale 1ns/1ps

module pdp8_memory (
	input  logic            i_clk,
	input  pdp8_pkg::addr_t i_addr,   // Shared read/write address
	input  pdp8_pkg::word_t i_wdata,  // Store data
	input  logic            i_we,     // Write at this edge
	output pdp8_pkg::word_t o_rdata   // Word one cycle after the address
);

	pdp8_pkg::word_t mem [pdp8_pkg::MEM_WORDS];  // Core array
	pdp8_pkg::word_t rdata_q;                    // Registered read word

	// Read sees the word as it was before a same-cycle write
	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[i_addr] <= i_wdata;  // Store takes effect at the edge
		end
		rdata_q <= mem[i_addr];      // Old contents on a collision
	end

	assign o_rdata = rdata_q;

endmodule

// ==== pdp8_pkg.sv ====
// PDP-8 core package with word and address widths, addressing constants, opcodes and result structs
package pdp8_pkg;

	// Machine widths
	localparam int WORD_W    = 12;                // One data word
	localparam int ADDR_W    = 12;                // Full 4K address
	localparam int MEM_WORDS = 1 << ADDR_W;       // 4096 words of core
	localparam int PAGE_W    = 5;                 // Page number, top of the address
	localparam int OFFSET_W  = ADDR_W - PAGE_W;   // Word within a 128-word page

	// Bit 11 is the machine's bit 0 (sign), bit 0 is the machine's bit 11
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Auto-index window on page zero
	localparam addr_t AUTOINDEX_FIRST = 12'o0010;  // First auto-index pointer
	localparam addr_t AUTOINDEX_LAST  = 12'o0017;  // Last auto-index pointer

	// Major opcode, instruction bits 11:9
	typedef enum logic [2:0] {
		OP_AND = 3'd0,  // AC and memory
		OP_TAD = 3'd1,  // Two's complement add
		OP_ISZ = 3'd2,  // Increment and skip on zero
		OP_DCA = 3'd3,  // Deposit and clear AC
		OP_JMS = 3'd4,  // Jump to subroutine
		OP_JMP = 3'd5,  // Jump
		OP_IOT = 3'd6,  // IO transfer, runs as a no-op here
		OP_OPR = 3'd7   // Operate microinstructions
	} opcode_e;

	// Programmer-visible registers
	typedef struct packed {
		word_t ac;    // Accumulator
		logic  link;  // Link bit
		word_t mq;    // Multiplier quotient
	} arch_regs_t;

	// Memory-reference unit output
	typedef struct packed {
		word_t ac;         // New AC
		logic  link;       // New link
		word_t mem_data;   // Word to store at the effective address
		logic  mem_write;  // Instruction stores a word
		logic  skip;       // ISZ wrapped to zero
	} mri_result_t;

	// Operate unit output
	typedef struct packed {
		word_t ac;    // New AC
		logic  link;  // New link
		word_t mq;    // New MQ
		logic  skip;  // Skip next instruction
		logic  halt;  // HLT seen
	} opr_result_t;

	// One memory port request
	typedef struct packed {
		addr_t addr;   // Word address
		word_t wdata;  // Store data
		logic  we;     // Write strobe
	} mem_req_t;

	// Host command strobes
	typedef struct packed {
		logic  load;   // Write data to addr
		logic  start;  // Run from addr
		addr_t addr;   // Load address or start PC
		word_t data;   // Load data
	} host_cmd_t;

endpackage
